// File: src/harness_defines.svh
`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

// uut data widths
`define HARNESS_WORD_W 64
`define HARNESS_RESULT_W 32
`define HARNESS_FEED_W 32

// card geometry
`define HARNESS_BLOCK_BYTES 512
`define HARNESS_START_BLOCK 32'h0010_0000

// control block check
`define HARNESS_SIGNATURE 32'haabb_ccdd

// execution limit in cycles
`define HARNESS_TIMEOUT 32'd4096

`endif

// File: src/sd_host_pkg.sv
`default_nettype none

package sd_host_pkg;

  // request lines towards the card host
  typedef struct packed {
    logic rst;
    logic r_block;
    logic r_multi;
    logic r_byte;
  } sd_req_t;

  // one byte from the card
  typedef logic [7:0] sd_byte_t;

endpackage : sd_host_pkg

`default_nettype wire

// File: src/test_record_pkg.sv
`default_nettype none

`include "harness_defines.svh"

package test_record_pkg;

  typedef logic [`HARNESS_FEED_W-1:0] feed_word_t;
  typedef logic [`HARNESS_RESULT_W-1:0] result_word_t;

  // fields of the control block, see capture for byte order
  typedef struct packed {
    logic [31:0] signature;
    logic [`HARNESS_WORD_W-1:0] uut_input;
    logic [31:0] next_block;
    logic [31:0] total_bytes;
    result_word_t expected;
  } ctrl_record_t;

  // control lines towards the uut
  typedef struct packed {
    logic rst;
    logic feed;
    logic stop;
  } uut_ctrl_t;

endpackage : test_record_pkg

`default_nettype wire

// File: src/harness_fsm.sv
`default_nettype none

module harness_fsm
  import sd_host_pkg::*;
  import test_record_pkg::*;
(
  input  wire       clk,
  input  wire       rst,
  input  wire       start_i,
  input  wire       sd_busy_i,
  input  wire       uut_busy_i,
  input  wire       uut_end_i,
  input  wire       uut_err_i,
  input  wire       block_done_i,
  input  wire       feed_done_i,
  input  wire       timeout_i,
  input  wire       sig_ok_i,
  input  wire       word_full_i,
  output sd_req_t   sd_req_o,
  output uut_ctrl_t uut_ctrl_o,
  output logic      busy_o,
  output logic      byte_step_o,
  output logic      bytes_clear_o,
  output logic      block_load_o,
  output logic      block_step_o,
  output logic      block_commit_o,
  output logic      timer_run_o,
  output logic      timer_clear_o,
  output logic      capture_o,
  output logic      feed_capture_o,
  output logic      check_o
);

  typedef enum logic [4:0] {
    S_IDLE,
    S_HOST_RST,
    S_HOST_WAIT,
    S_CTRL_SETUP,
    S_CTRL_REQ,
    S_CTRL_WAIT,
    S_CTRL_BYTE,
    S_CTRL_BYTE_WAIT,
    S_CHECK_SIG,
    S_FEED_REQ,
    S_FEED_WAIT,
    S_FEED_BYTE,
    S_FEED_BYTE_WAIT,
    S_FEED_PUSH,
    S_UUT_WAIT_HI,
    S_UUT_WAIT_LO,
    S_STOP,
    S_END_WAIT,
    S_RESULT,
    S_COMPARE
  } state_t;

  state_t state_q;
  state_t state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    sd_req_o       = '0;
    uut_ctrl_o     = '0;
    busy_o         = 1'b1;
    byte_step_o    = 1'b0;
    bytes_clear_o  = 1'b0;
    block_load_o   = 1'b0;
    block_step_o   = 1'b0;
    block_commit_o = 1'b0;
    timer_run_o    = 1'b0;
    timer_clear_o  = 1'b0;
    capture_o      = 1'b0;
    feed_capture_o = 1'b0;
    check_o        = 1'b0;

    case (state_q)
      S_IDLE: begin
        busy_o = 1'b0;
        if (start_i) begin
          state_d = S_HOST_RST;
        end
      end
      S_HOST_RST: begin
        sd_req_o.rst   = 1'b1;
        uut_ctrl_o.rst = 1'b1;
        if (sd_busy_i) begin
          state_d = S_HOST_WAIT;
        end
      end
      S_HOST_WAIT: begin
        uut_ctrl_o.rst = 1'b1;
        if (!sd_busy_i) begin
          state_d = S_CTRL_SETUP;
        end
      end

      ////////////////////////////////////////
      // control block read
      ////////////////////////////////////////
      S_CTRL_SETUP: begin
        uut_ctrl_o.rst = 1'b1;
        bytes_clear_o  = 1'b1;
        block_load_o   = 1'b1;
        timer_clear_o  = 1'b1;
        if (!sd_busy_i) begin
          state_d = S_CTRL_REQ;
        end
      end
      S_CTRL_REQ: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        if (sd_busy_i) begin
          state_d = S_CTRL_WAIT;
        end
      end
      S_CTRL_WAIT: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        if (!sd_busy_i) begin
          state_d = S_CTRL_BYTE;
        end
      end
      S_CTRL_BYTE: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        if (block_done_i) begin
          state_d = S_CHECK_SIG;
        end else begin
          sd_req_o.r_byte = 1'b1;
          if (sd_busy_i) begin
            state_d = S_CTRL_BYTE_WAIT;
          end
        end
      end
      S_CTRL_BYTE_WAIT: begin
        uut_ctrl_o.rst   = 1'b1;
        sd_req_o.r_block = 1'b1;
        // byte valid as busy falls
        if (!sd_busy_i) begin
          capture_o   = 1'b1;
          byte_step_o = 1'b1;
          state_d     = S_CTRL_BYTE;
        end
      end
      S_CHECK_SIG: begin
        uut_ctrl_o.rst = 1'b1;
        if (sig_ok_i) begin
          bytes_clear_o = 1'b1;
          block_step_o  = 1'b1;
          state_d       = S_FEED_REQ;
        end else begin
          state_d = S_IDLE;
        end
      end

      ////////////////////////////////////////
      // feed loop
      ////////////////////////////////////////
      S_FEED_REQ: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (sd_busy_i) begin
          state_d = S_FEED_WAIT;
        end
      end
      S_FEED_WAIT: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (!sd_busy_i) begin
          state_d = S_FEED_BYTE;
        end
      end
      S_FEED_BYTE: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (word_full_i) begin
          state_d = S_FEED_PUSH;
        end else if (feed_done_i) begin
          state_d = S_STOP;
        end else begin
          sd_req_o.r_byte = 1'b1;
          if (sd_busy_i) begin
            state_d = S_FEED_BYTE_WAIT;
          end
        end
      end
      S_FEED_BYTE_WAIT: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (!sd_busy_i) begin
          feed_capture_o = 1'b1;
          byte_step_o    = 1'b1;
          state_d        = S_FEED_BYTE;
        end
      end
      S_FEED_PUSH: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (!uut_busy_i) begin
          uut_ctrl_o.feed = 1'b1;
          state_d         = S_UUT_WAIT_HI;
        end
      end
      S_UUT_WAIT_HI: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (uut_busy_i) begin
          state_d = S_UUT_WAIT_LO;
        end
      end
      S_UUT_WAIT_LO: begin
        timer_run_o      = 1'b1;
        sd_req_o.r_multi = 1'b1;
        if (!uut_busy_i) begin
          state_d = S_FEED_BYTE;
        end
      end

      ////////////////////////////////////////
      // end of test
      ////////////////////////////////////////
      S_STOP: begin
        timer_run_o     = 1'b1;
        uut_ctrl_o.stop = 1'b1;
        state_d         = S_END_WAIT;
      end
      S_END_WAIT: begin
        timer_run_o = 1'b1;
        if (uut_end_i || uut_err_i || timeout_i) begin
          state_d = S_RESULT;
        end
      end
      S_RESULT: begin
        check_o = 1'b1;
        state_d = S_COMPARE;
      end
      S_COMPARE: begin
        // let the multi read wind down first
        if (!sd_busy_i) begin
          block_commit_o = 1'b1;
          state_d        = S_CTRL_SETUP;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

endmodule : harness_fsm

`default_nettype wire

// File: src/test_counters.sv
`default_nettype none

`include "harness_defines.svh"

module test_counters (
  input  wire         clk,
  input  wire         rst,
  input  wire         byte_step_i,
  input  wire         bytes_clear_i,
  input  wire         block_load_i,
  input  wire         block_step_i,
  input  wire         block_commit_i,
  input  wire         timer_run_i,
  input  wire         timer_clear_i,
  input  wire  [31:0] next_block_i,
  input  wire  [31:0] total_bytes_i,
  output logic [31:0] block_addr_o,
  output logic [31:0] byte_offset_o,
  output logic        block_done_o,
  output logic        feed_done_o,
  output logic        timeout_o
);

  logic [31:0] ctrl_block_q;
  logic [31:0] timer_q;

  // control block register and card address
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_block_q <= `HARNESS_START_BLOCK;
      block_addr_o <= `HARNESS_START_BLOCK;
    end else begin
      if (block_commit_i) begin
        ctrl_block_q <= next_block_i;
      end
      if (block_load_i) begin
        block_addr_o <= ctrl_block_q;
      end else if (block_step_i) begin
        block_addr_o <= block_addr_o + 32'd1;
      end
    end
  end

  // byte offset in control block, byte count in feed phase
  always_ff @(posedge clk) begin
    if (rst || bytes_clear_i) begin
      byte_offset_o <= '0;
    end else if (byte_step_i) begin
      byte_offset_o <= byte_offset_o + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || timer_clear_i) begin
      timer_q <= '0;
    end else if (timer_run_i) begin
      timer_q <= timer_q + 32'd1;
    end
  end

  assign block_done_o = (byte_offset_o == 32'(`HARNESS_BLOCK_BYTES));
  assign feed_done_o  = (byte_offset_o >= total_bytes_i);
  assign timeout_o    = (timer_q > `HARNESS_TIMEOUT);

endmodule : test_counters

`default_nettype wire

// File: src/ctrl_block_capture.sv
`default_nettype none

`include "harness_defines.svh"

module ctrl_block_capture
  import sd_host_pkg::*;
  import test_record_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          capture_i,
  input  wire   [31:0] byte_offset_i,
  input  sd_byte_t     sd_data_i,
  output ctrl_record_t record_o,
  output logic         sig_ok_o
);

  logic [4:0] off;
  logic [2:0] in_lane;
  logic       in_record;

  assign off       = byte_offset_i[4:0];
  assign in_lane   = 3'(off - 5'd4);
  assign in_record = (byte_offset_i < 32'd24);

  always_ff @(posedge clk) begin
    if (rst) begin
      record_o <= '0;
    end else if (capture_i) begin
      // fresh record on first byte of each block
      if (byte_offset_i == 32'd0) begin
        record_o <= '0;
      end
      if (in_record) begin
        if (off < 5'd4) begin
          // signature comes msb first
          record_o.signature[{~off[1:0], 3'b000} +: 8] <= sd_data_i;
        end else if (off < 5'd12) begin
          record_o.uut_input[{in_lane, 3'b000} +: 8] <= sd_data_i;
        end else if (off < 5'd16) begin
          record_o.next_block[{off[1:0], 3'b000} +: 8] <= sd_data_i;
        end else if (off < 5'd20) begin
          record_o.total_bytes[{off[1:0], 3'b000} +: 8] <= sd_data_i;
        end else begin
          record_o.expected[{off[1:0], 3'b000} +: 8] <= sd_data_i;
        end
      end
    end
  end

  assign sig_ok_o = (record_o.signature == `HARNESS_SIGNATURE);

endmodule : ctrl_block_capture

`default_nettype wire

// File: src/feed_assembler.sv
`default_nettype none

`include "harness_defines.svh"

module feed_assembler
  import sd_host_pkg::*;
  import test_record_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        feed_capture_i,
  input  sd_byte_t   sd_data_i,
  output feed_word_t feed_data_o,
  output logic       word_full_o
);

  logic [1:0] count_q;

  // first byte ends up most significant
  always_ff @(posedge clk) begin
    if (feed_capture_i) begin
      feed_data_o <= {feed_data_o[`HARNESS_FEED_W-9:0], sd_data_i};
    end
  end

  // count wraps as the fourth byte lands, full flags one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q     <= '0;
      word_full_o <= 1'b0;
    end else begin
      word_full_o <= feed_capture_i && (count_q == 2'd3);
      if (feed_capture_i) begin
        count_q <= count_q + 2'd1;
      end
    end
  end

endmodule : feed_assembler

`default_nettype wire

// File: src/result_checker.sv
`default_nettype none

module result_checker
  import test_record_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          check_i,
  input  result_word_t uut_result_i,
  input  wire          uut_err_i,
  input  result_word_t expected_i,
  output logic [31:0]  error_count_o
);

  result_word_t result_q;
  logic         err_q;
  logic         cmp_q;

  always_ff @(posedge clk) begin
    if (check_i) begin
      result_q <= uut_result_i;
      err_q    <= uut_err_i;
    end
  end

  // compare one cycle after capture
  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_q         <= 1'b0;
      error_count_o <= '0;
    end else begin
      cmp_q <= check_i;
      if (cmp_q && (err_q || (result_q != expected_i))) begin
        error_count_o <= error_count_o + 32'd1;
      end
    end
  end

endmodule : result_checker

`default_nettype wire

// File: src/harness_top.sv
`default_nettype none

`include "harness_defines.svh"

module harness_top
  import sd_host_pkg::*;
  import test_record_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        start_i,
  input  wire                        sd_busy_i,
  input  sd_byte_t                   sd_data_i,
  output sd_req_t                    sd_req_o,
  output logic [31:0]                sd_block_addr_o,
  input  wire                        uut_busy_i,
  input  wire                        uut_end_i,
  input  wire                        uut_err_i,
  input  result_word_t               uut_result_i,
  output uut_ctrl_t                  uut_ctrl_o,
  output logic [`HARNESS_WORD_W-1:0] uut_input_o,
  output feed_word_t                 feed_data_o,
  output logic [31:0]                error_count_o,
  output logic                       busy_o
);

  logic         byte_step;
  logic         bytes_clear;
  logic         block_load;
  logic         block_step;
  logic         block_commit;
  logic         timer_run;
  logic         timer_clear;
  logic         capture;
  logic         feed_capture;
  logic         check;
  logic         block_done;
  logic         feed_done;
  logic         timeout;
  logic         sig_ok;
  logic         word_full;
  logic [31:0]  byte_offset;
  ctrl_record_t record;

  assign uut_input_o = record.uut_input;

  harness_fsm u_fsm (
    .clk            (clk),
    .rst            (rst),
    .start_i        (start_i),
    .sd_busy_i      (sd_busy_i),
    .uut_busy_i     (uut_busy_i),
    .uut_end_i      (uut_end_i),
    .uut_err_i      (uut_err_i),
    .block_done_i   (block_done),
    .feed_done_i    (feed_done),
    .timeout_i      (timeout),
    .sig_ok_i       (sig_ok),
    .word_full_i    (word_full),
    .sd_req_o       (sd_req_o),
    .uut_ctrl_o     (uut_ctrl_o),
    .busy_o         (busy_o),
    .byte_step_o    (byte_step),
    .bytes_clear_o  (bytes_clear),
    .block_load_o   (block_load),
    .block_step_o   (block_step),
    .block_commit_o (block_commit),
    .timer_run_o    (timer_run),
    .timer_clear_o  (timer_clear),
    .capture_o      (capture),
    .feed_capture_o (feed_capture),
    .check_o        (check)
  );

  test_counters u_counters (
    .clk            (clk),
    .rst            (rst),
    .byte_step_i    (byte_step),
    .bytes_clear_i  (bytes_clear),
    .block_load_i   (block_load),
    .block_step_i   (block_step),
    .block_commit_i (block_commit),
    .timer_run_i    (timer_run),
    .timer_clear_i  (timer_clear),
    .next_block_i   (record.next_block),
    .total_bytes_i  (record.total_bytes),
    .block_addr_o   (sd_block_addr_o),
    .byte_offset_o  (byte_offset),
    .block_done_o   (block_done),
    .feed_done_o    (feed_done),
    .timeout_o      (timeout)
  );

  ctrl_block_capture u_capture (
    .clk           (clk),
    .rst           (rst),
    .capture_i     (capture),
    .byte_offset_i (byte_offset),
    .sd_data_i     (sd_data_i),
    .record_o      (record),
    .sig_ok_o      (sig_ok)
  );

  feed_assembler u_feed (
    .clk            (clk),
    .rst            (rst),
    .feed_capture_i (feed_capture),
    .sd_data_i      (sd_data_i),
    .feed_data_o    (feed_data_o),
    .word_full_o    (word_full)
  );

  result_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .check_i       (check),
    .uut_result_i  (uut_result_i),
    .uut_err_i     (uut_err_i),
    .expected_i    (record.expected),
    .error_count_o (error_count_o)
  );

endmodule : harness_top

`default_nettype wire

// File: verification/harness_models.sv
`default_nettype none

`include "harness_defines.svh"

// card host model, level handshake with random busy lengths
module card_model
  import sd_host_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  sd_req_t     req_i,
  input  wire  [31:0] addr_i,
  output logic        busy_o,
  output sd_byte_t    data_o
);

  logic [7:0]  mem [longint];
  logic [31:0] lfsr;
  logic        opened;
  logic [31:0] cur_addr;
  int unsigned idx;
  int unsigned wait_left;
  logic        busy_n;
  sd_byte_t    data_n;
  sd_byte_t    pending;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task take_bits(input int n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [7:0] read_byte(input logic [31:0] a, input int unsigned i);
    longint key;
    key = longint'(a) * 512 + i;
    if (mem.exists(key)) begin
      return mem[key];
    end
    // fill from every address bit
    return key[7:0] ^ key[15:8] ^ key[23:16] ^ key[31:24] ^ key[39:32] ^ key[47:40] ^
           8'h5a;
  endfunction

  initial begin
    busy_o    = 1'b0;
    data_o    = '0;
    pending   = '0;
    lfsr      = 32'hab31;
    opened    = 1'b0;
    cur_addr  = '0;
    idx       = 0;
    wait_left = 0;
  end

  always @(posedge clk) begin
    busy_n = busy_o;
    data_n = data_o;
    if (rst) begin
      busy_n = 1'b0;
      opened = 1'b0;
    end else if (busy_o) begin
      if (wait_left == 0) begin
        busy_n = 1'b0;
        data_n = pending;
      end else begin
        wait_left = wait_left - 1;
      end
    end else begin
      if (!req_i.r_block && !req_i.r_multi) begin
        opened = 1'b0;
      end
      if (req_i.rst) begin
        opened = 1'b0;
        busy_n = 1'b1;
      end else if ((req_i.r_block || req_i.r_multi) && !opened) begin
        opened   = 1'b1;
        cur_addr = addr_i;
        idx      = 0;
        busy_n   = 1'b1;
      end else if (opened && req_i.r_byte) begin
        pending = read_byte(cur_addr, idx);
        idx     = idx + 1;
        // multi reads run on into the next block
        if (idx == `HARNESS_BLOCK_BYTES) begin
          idx      = 0;
          cur_addr = cur_addr + 1;
        end
        busy_n = 1'b1;
      end
      if (busy_n) begin
        take_bits(2, wait_left);
      end
    end
    #1;
    busy_o = busy_n;
    data_o = data_n;
  end

endmodule : card_model

// uut model, config latched per feed and per stop
module uut_model
  import test_record_pkg::*;
(
  input  wire          clk,
  input  uut_ctrl_t    ctrl_i,
  input  wire    [7:0] busy_cycles_i,
  input  wire    [7:0] end_delay_i,
  input  wire          never_end_i,
  input  wire          err_cfg_i,
  input  result_word_t result_cfg_i,
  output logic         busy_o,
  output logic         end_o,
  output logic         err_o,
  output result_word_t result_o
);

  int unsigned  busy_left;
  int unsigned  end_left;
  logic         armed;
  logic         hang;
  logic         fail_err;
  logic         busy_n;
  logic         end_n;
  logic         err_n;
  result_word_t res_n;

  initial begin
    busy_o   = 1'b0;
    end_o    = 1'b0;
    err_o    = 1'b0;
    result_o = '0;
    armed    = 1'b0;
    hang     = 1'b0;
    fail_err = 1'b0;
  end

  always @(posedge clk) begin
    busy_n = busy_o;
    end_n  = end_o;
    err_n  = err_o;
    res_n  = result_o;
    if (ctrl_i.rst) begin
      busy_n = 1'b0;
      end_n  = 1'b0;
      err_n  = 1'b0;
      armed  = 1'b0;
    end else begin
      if (busy_o) begin
        if (busy_left == 0) begin
          busy_n = 1'b0;
        end else begin
          busy_left = busy_left - 1;
        end
      end
      if (ctrl_i.feed) begin
        busy_n    = 1'b1;
        busy_left = busy_cycles_i;
      end
      if (ctrl_i.stop) begin
        armed    = 1'b1;
        end_left = end_delay_i;
        fail_err = err_cfg_i;
        hang     = never_end_i;
        res_n    = result_cfg_i;
      end else if (armed && !hang) begin
        // end or err held until the next uut reset
        if (end_left == 0) begin
          armed = 1'b0;
          end_n = !fail_err;
          err_n = fail_err;
        end else begin
          end_left = end_left - 1;
        end
      end
    end
    #1;
    busy_o   = busy_n;
    end_o    = end_n;
    err_o    = err_n;
    result_o = res_n;
  end

endmodule : uut_model

`default_nettype wire

// File: verification/tb_harness.sv
`default_nettype none

`include "harness_defines.svh"

module tb_harness
  import sd_host_pkg::*;
  import test_record_pkg::*;
();

  localparam int NUM_TESTS = 5;
  localparam int BAD_TEST  = 4;
  localparam longint WATCHDOG_TIME =
    (longint'(NUM_TESTS * `HARNESS_BLOCK_BYTES + 64) * 12 + `HARNESS_TIMEOUT + 2000) * 10;

  logic                       clk;
  logic                       rst;
  logic                       start;
  logic                       started;
  logic                       sd_busy;
  sd_byte_t                   sd_data;
  sd_req_t                    sd_req;
  logic [31:0]                sd_addr;
  logic                       uut_busy;
  logic                       uut_end;
  logic                       uut_err;
  result_word_t               uut_result;
  uut_ctrl_t                  uut_ctrl;
  logic [`HARNESS_WORD_W-1:0] uut_input;
  feed_word_t                 feed_data;
  logic [31:0]                err_count;
  logic                       busy;

  // per test table
  logic [31:0]                ctrl_addr [0:NUM_TESTS-1];
  logic [31:0]                next_blk [0:NUM_TESTS-1];
  logic [31:0]                total [0:NUM_TESTS-1];
  logic [`HARNESS_WORD_W-1:0] exp_input [0:NUM_TESTS-1];
  result_word_t               expected [0:NUM_TESTS-1];
  result_word_t               result_cfg [0:NUM_TESTS-1];
  logic                       err_cfg [0:NUM_TESTS-1];
  logic                       never_cfg [0:NUM_TESTS-1];
  logic [7:0]                 busy_cfg [0:NUM_TESTS-1];
  logic [7:0]                 delay_cfg [0:NUM_TESTS-1];
  int                         fails [0:NUM_TESTS-1];
  int                         exp_count [0:NUM_TESTS-1];
  feed_word_t                 exp_words [0:NUM_TESTS-1][0:7];

  // scoreboard state
  int                         test_idx;
  int                         feed_idx;
  int                         exp_errors;
  logic [31:0]                exp_ctrl_addr;
  logic                       halted;

  harness_top DUT (
    .clk             (clk),
    .rst             (rst),
    .start_i         (start),
    .sd_busy_i       (sd_busy),
    .sd_data_i       (sd_data),
    .sd_req_o        (sd_req),
    .sd_block_addr_o (sd_addr),
    .uut_busy_i      (uut_busy),
    .uut_end_i       (uut_end),
    .uut_err_i       (uut_err),
    .uut_result_i    (uut_result),
    .uut_ctrl_o      (uut_ctrl),
    .uut_input_o     (uut_input),
    .feed_data_o     (feed_data),
    .error_count_o   (err_count),
    .busy_o          (busy)
  );

  card_model u_card (
    .clk    (clk),
    .rst    (rst),
    .req_i  (sd_req),
    .addr_i (sd_addr),
    .busy_o (sd_busy),
    .data_o (sd_data)
  );

  uut_model u_uut (
    .clk           (clk),
    .ctrl_i        (uut_ctrl),
    .busy_cycles_i (busy_cfg[test_idx]),
    .end_delay_i   (delay_cfg[test_idx]),
    .never_end_i   (never_cfg[test_idx]),
    .err_cfg_i     (err_cfg[test_idx]),
    .result_cfg_i  (result_cfg[test_idx]),
    .busy_o        (uut_busy),
    .end_o         (uut_end),
    .err_o         (uut_err),
    .result_o      (uut_result)
  );

  always #5 clk = ~clk;

  task report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task set_test(input int t, input logic [31:0] addr, input logic [31:0] nxt,
                input logic [31:0] nbytes, input logic [63:0] in_word,
                input logic [31:0] exp_res, input logic [31:0] res,
                input logic err, input logic never, input logic [7:0] bcyc,
                input logic [7:0] dly, input int nfail);
    ctrl_addr[t]  = addr;
    next_blk[t]   = nxt;
    total[t]      = nbytes;
    exp_input[t]  = in_word;
    expected[t]   = exp_res;
    result_cfg[t] = res;
    err_cfg[t]    = err;
    never_cfg[t]  = never;
    busy_cfg[t]   = bcyc;
    delay_cfg[t]  = dly;
    fails[t]      = nfail;
    exp_count[t]  = nbytes / 4;
  endtask

  // control block image, byte order per record layout
  task write_record(input int t, input logic [31:0] sig);
    longint base;
    base = longint'(ctrl_addr[t]) * 512;
    for (int i = 0; i < 4; i++) begin
      u_card.mem[base + i]      = sig[8 * (3 - i) +: 8];
      u_card.mem[base + 12 + i] = next_blk[t][8 * i +: 8];
      u_card.mem[base + 16 + i] = total[t][8 * i +: 8];
      u_card.mem[base + 20 + i] = expected[t][8 * i +: 8];
    end
    for (int i = 0; i < 8; i++) begin
      u_card.mem[base + 4 + i] = exp_input[t][8 * i +: 8];
    end
    for (int k = 0; k < exp_count[t]; k++) begin
      for (int j = 0; j < 4; j++) begin
        exp_words[t][k][8 * (3 - j) +: 8] = u_card.read_byte(ctrl_addr[t] + 1, 4 * k + j);
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rst && uut_ctrl.stop) begin
      test_idx      <= test_idx + 1;
      feed_idx      <= 0;
      exp_errors    <= exp_errors + fails[test_idx];
      exp_ctrl_addr <= next_blk[test_idx];
    end else if (!rst && uut_ctrl.feed) begin
      feed_idx <= feed_idx + 1;
    end
  end

  // latched once the harness drops back to idle after the bad block
  always @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (test_idx == BAD_TEST && !busy) begin
      halted <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_idle: assert property (@(posedge clk) disable iff (rst)
    !started |-> (sd_req == '0 && uut_ctrl == '0 && err_count == 0 && !busy))
    else report_mismatch("outputs active before start");
  a_feed_word: assert property (@(posedge clk) disable iff (rst)
    uut_ctrl.feed |-> (feed_idx < exp_count[test_idx] &&
                       feed_data == exp_words[test_idx][feed_idx]))
    else report_mismatch("feed word wrong or extra feed pulse");
  a_input: assert property (@(posedge clk) disable iff (rst)
    uut_ctrl.feed |-> uut_input == exp_input[test_idx])
    else report_mismatch("uut input word differs from record");
  a_stop: assert property (@(posedge clk) disable iff (rst)
    uut_ctrl.stop |-> feed_idx == exp_count[test_idx])
    else report_mismatch("stop pulse with wrong feed count");
  a_ctrl_addr: assert property (@(posedge clk) disable iff (rst)
    sd_req.r_block |-> sd_addr == exp_ctrl_addr)
    else report_mismatch("control block read at wrong address");
  a_uut_rst: assert property (@(posedge clk) disable iff (rst)
    sd_req.r_block |-> uut_ctrl.rst)
    else report_mismatch("uut not held in reset during control block read");
  a_feed_addr: assert property (@(posedge clk) disable iff (rst)
    sd_req.r_multi |-> sd_addr == exp_ctrl_addr + 32'd1)
    else report_mismatch("feed read at wrong address");
  a_errors: assert property (@(posedge clk) disable iff (rst)
    sd_req.r_block |-> err_count == exp_errors)
    else report_mismatch("error count wrong");
  a_bad_sig: assert property (@(posedge clk) disable iff (rst)
    test_idx == BAD_TEST |-> (!uut_ctrl.feed && !uut_ctrl.stop))
    else report_mismatch("feed or stop after bad signature");
  a_no_reread: assert property (@(posedge clk) disable iff (rst)
    halted |-> (!busy && sd_req == '0 && err_count == exp_errors))
    else report_mismatch("harness active after bad signature");

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the harness finished all tests");
    $display("Verification failed");
    $fatal(1);
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    start         = 1'b0;
    started       = 1'b0;
    test_idx      = 0;
    feed_idx      = 0;
    exp_errors    = 0;
    exp_ctrl_addr = `HARNESS_START_BLOCK;
    set_test(0, `HARNESS_START_BLOCK, 32'h200, 32'd16, 64'h0123_4567_89ab_cdef,
             32'h1111_2222, 32'h1111_2222, 1'b0, 1'b0, 8'd2, 8'd3, 0);
    set_test(1, 32'h200, 32'h300, 32'd8, 64'hfeed_0000_beef_0001,
             32'h3333_4444, 32'h3333_4445, 1'b0, 1'b0, 8'd0, 8'd0, 1);
    set_test(2, 32'h300, 32'h400, 32'd4, 64'h0000_0000_0000_0042,
             32'h5555_6666, 32'h5555_6666, 1'b1, 1'b0, 8'd5, 8'd1, 1);
    // uut never ends, result stays off
    set_test(3, 32'h400, 32'h500, 32'd4, 64'h8000_0000_0000_0001,
             32'h7777_8888, 32'h8888_7777, 1'b0, 1'b1, 8'd1, 8'd0, 1);
    set_test(4, 32'h500, 32'h0, 32'd4, 64'h0, 32'h0, 32'h0, 1'b0, 1'b0, 8'd0, 8'd0, 0);
    for (int t = 0; t < BAD_TEST; t++) begin
      write_record(t, `HARNESS_SIGNATURE);
    end
    write_record(BAD_TEST, `HARNESS_SIGNATURE ^ 32'h0000_0100);

    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    start   = 1'b1;
    started = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;

    wait (test_idx == BAD_TEST && !busy);
    repeat (100) @(posedge clk);
    assert (err_count == 32'd3 && exp_errors == 3)
      else report_mismatch("final error count wrong");
    assert (!busy && sd_req == '0)
      else report_mismatch("harness not idle after bad signature");
    $display("Verification passed");
    $finish;
  end

endmodule : tb_harness

`default_nettype wire

// File: files.f
+incdir+src
src/sd_host_pkg.sv
src/test_record_pkg.sv
src/harness_fsm.sv
src/test_counters.sv
src/ctrl_block_capture.sv
src/feed_assembler.sv
src/result_checker.sv
src/harness_top.sv
verification/harness_models.sv
verification/tb_harness.sv
